/* psgBusPkg.sv */
`default_nettype none

// ========================================
// memory bus definitions
// ========================================

package psgBusPkg;

	// command a channel drives onto the shared wavetable port
	typedef enum logic [1:0] {
		busIdle,
		busRead,
		busWrite
	} busCmd;

	// wavetable read sequencer
	// msBusy lasts one cycle, so a read returns two cycles after it is taken
	typedef enum logic {
		msIdle,
		msBusy
	} memState;

endpackage

`default_nettype wire

/* psgVoicePkg.sv */
`default_nettype none

// ========================================
// voice channel definitions
// ========================================

package psgVoicePkg;

	// low two bits of a host register address
	typedef enum logic [1:0] {
		regFreq,
		regVol,
		regBase,
		regCtrl
	} regSel;

	// per-voice sample fetch sequence
	typedef enum logic [1:0] {
		fsIdle,
		fsWaitGrant,
		fsWaitData
	} fetchState;

endpackage

`default_nettype wire

/* psgBusArb.sv */
`timescale 1ns/1ps
`default_nettype none

// fixed-priority arbiter for the wavetable port
// lowest requesting index wins, grant only moves while ce and ack are high
module psgBusArb #(
	parameter int numChannels = 4
) (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic ack,
	input logic [numChannels-1:0] req,
	output logic [numChannels-1:0] sel,
	output logic [$clog2(numChannels)-1:0] owner
);

	localparam int ownerWidth = $clog2(numChannels);

	logic [ownerWidth-1:0] winner;
	logic anyReq;

	// scan from the top so the lowest index is the one left standing
	always_comb begin
		winner = '0;
		for (int i = numChannels - 1; i >= 0; i--) begin
			if (req[i]) begin
				winner = ownerWidth'(i);
			end
		end
	end

	assign anyReq = |req;

	// ========================================
	// grant registers
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= '0;
			owner <= '0;
		end else if (ce && ack && anyReq) begin
			sel <= numChannels'(1) << winner;
			owner <= winner;
		end
		// with nobody asking the last owner keeps the bus
	end

endmodule

`default_nettype wire

/* psgWaveMem.sv */
`timescale 1ns/1ps
`default_nettype none

// wavetable RAM
// host writes on one port, tagged channel reads on the other
module psgWaveMem #(
	parameter int sampleWidth = 8,
	parameter int tableAddrWidth = 10,
	parameter int tagWidth = 2
) (
	input logic clk,
	input logic rst,
	input logic tblWr,
	input logic [tableAddrWidth-1:0] tblAddr,
	input logic [sampleWidth-1:0] tblData,
	input psgBusPkg::busCmd cmd,
	input logic [tableAddrWidth-1:0] addr,
	input logic [tagWidth-1:0] tag,
	output logic ack,
	output logic [sampleWidth-1:0] rdData,
	output logic [tagWidth-1:0] rdTag,
	output logic dataVld
);

	logic [sampleWidth-1:0] waveRam [2**tableAddrWidth];
	psgBusPkg::memState state;
	logic [tableAddrWidth-1:0] rdAddr;
	logic [tagWidth-1:0] tagHold;
	logic accept;

	// host side, a single cycle and no effect on ack
	always_ff @(posedge clk) begin
		if (tblWr) begin
			waveRam[tblAddr] <= tblData;
		end
	end

	assign ack = (state == psgBusPkg::msIdle);
	assign accept = ack && (cmd == psgBusPkg::busRead);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= psgBusPkg::msIdle;
			dataVld <= 1'b0;
		end else begin
			dataVld <= (state == psgBusPkg::msBusy);
			if (accept) begin
				state <= psgBusPkg::msBusy;
			end else begin
				state <= psgBusPkg::msIdle;
			end
		end
	end

	// address and owner tag captured at accept, data out one cycle later
	always_ff @(posedge clk) begin
		if (accept) begin
			rdAddr <= addr;
			tagHold <= tag;
		end
		if (state == psgBusPkg::msBusy) begin
			rdData <= waveRam[rdAddr];
			rdTag <= tagHold;
		end
	end

endmodule

`default_nettype wire

/* psgWaveChannel.sv */
`timescale 1ns/1ps
`default_nettype none

// one wavetable voice
module psgWaveChannel #(
	parameter int chanId = 0,
	parameter int numChannels = 4,
	parameter int sampleWidth = 8,
	parameter int tableAddrWidth = 10,
	parameter int phaseWidth = 16,
	parameter int volWidth = 4
) (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic regWr,
	input logic [$clog2(numChannels)+1:0] regAddr,
	input logic [phaseWidth-1:0] regData,
	input logic [numChannels-1:0] sel,
	input logic ack,
	input logic [sampleWidth-1:0] rdData,
	input logic [$clog2(numChannels)-1:0] rdTag,
	input logic dataVld,
	output logic req,
	output psgBusPkg::busCmd cmd,
	output logic [tableAddrWidth-1:0] addr,
	output logic [sampleWidth-1:0] sample,
	output logic [volWidth-1:0] volume,
	output logic enable
);

	localparam int chanBits = $clog2(numChannels);

	logic [phaseWidth-1:0] freq;
	logic [tableAddrWidth-1:0] base;
	logic [phaseWidth-1:0] phase;
	logic [phaseWidth-1:0] nextPhase;
	logic [tableAddrWidth-1:0] idxNow;
	logic [tableAddrWidth-1:0] idxNext;
	psgVoicePkg::fetchState fState;
	logic regHit;
	logic ctrlOff;
	logic idxStep;
	logic issue;
	logic tagMatch;

	// ========================================
	// host registers
	// ========================================

	// upper address bits pick the voice
	assign regHit = regWr && (regAddr[chanBits+1:2] == chanBits'(chanId));
	assign ctrlOff = regHit && (regAddr[1:0] == psgVoicePkg::regCtrl) && !regData[0];

	always_ff @(posedge clk) begin
		if (rst) begin
			freq <= '0;
			volume <= '0;
			base <= '0;
			enable <= 1'b0;
		end else if (regHit) begin
			case (psgVoicePkg::regSel'(regAddr[1:0]))
				psgVoicePkg::regFreq: freq <= regData;
				psgVoicePkg::regVol: volume <= regData[volWidth-1:0];
				psgVoicePkg::regBase: base <= regData[tableAddrWidth-1:0];
				psgVoicePkg::regCtrl: enable <= regData[0];
			endcase
		end
	end

	// ========================================
	// phase accumulator
	// ========================================

	assign nextPhase = phase + freq;
	assign idxNow = phase[phaseWidth-1 -: tableAddrWidth];
	assign idxNext = nextPhase[phaseWidth-1 -: tableAddrWidth];
	assign idxStep = ce && enable && (idxNext != idxNow);

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= '0;
		end else if (ce && enable) begin
			phase <= nextPhase;
		end
	end

	// ========================================
	// sample fetch
	// ========================================

	assign req = (fState != psgVoicePkg::fsIdle);
	assign issue = (fState == psgVoicePkg::fsWaitGrant) && sel[chanId] && ack;
	assign cmd = issue ? psgBusPkg::busRead : psgBusPkg::busIdle;
	// table address wraps around the end of the RAM
	assign addr = base + idxNow;
	assign tagMatch = dataVld && (rdTag == chanBits'(chanId));

	always_ff @(posedge clk) begin
		if (rst) begin
			fState <= psgVoicePkg::fsIdle;
			sample <= '0;
		end else if (ctrlOff) begin
			// a disabled voice goes silent at once
			fState <= psgVoicePkg::fsIdle;
			sample <= '0;
		end else begin
			case (fState)
				psgVoicePkg::fsIdle: begin
					if (idxStep) begin
						fState <= psgVoicePkg::fsWaitGrant;
					end
				end
				psgVoicePkg::fsWaitGrant: begin
					if (issue) begin
						fState <= psgVoicePkg::fsWaitData;
					end
				end
				psgVoicePkg::fsWaitData: begin
					if (tagMatch) begin
						sample <= rdData;
						fState <= psgVoicePkg::fsIdle;
					end
				end
				default: fState <= psgVoicePkg::fsIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* psgMixer.sv */
`timescale 1ns/1ps
`default_nettype none

// volume scaling and summing of the voices
module psgMixer #(
	parameter int numChannels = 4,
	parameter int sampleWidth = 8,
	parameter int volWidth = 4
) (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic [numChannels-1:0][sampleWidth-1:0] samples,
	input logic [numChannels-1:0][volWidth-1:0] volumes,
	input logic [numChannels-1:0] enables,
	output logic signed [sampleWidth+volWidth+$clog2(numChannels)-1:0] audio
);

	localparam int sumWidth = sampleWidth + volWidth + $clog2(numChannels);

	logic signed [sumWidth-1:0] mixSum;

	// signed sample times unsigned volume, one product per voice
	always_comb begin
		logic signed [sumWidth-1:0] prod;
		mixSum = '0;
		for (int i = 0; i < numChannels; i++) begin
			prod = $signed(samples[i]) * $signed({1'b0, volumes[i]});
			if (enables[i]) begin
				mixSum = mixSum + prod;
			end
		end
	end

	// output moves once per sample tick
	always_ff @(posedge clk) begin
		if (rst) begin
			audio <= '0;
		end else if (ce) begin
			audio <= mixSum;
		end
	end

endmodule

`default_nettype wire

/* psgWave.sv */
`timescale 1ns/1ps
`default_nettype none

// wavetable sound generator top
module psgWave #(
	parameter int numChannels = 4,
	parameter int sampleWidth = 8,
	parameter int tableAddrWidth = 10,
	parameter int phaseWidth = 16,
	parameter int volWidth = 4
) (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic regWr,
	input logic [$clog2(numChannels)+1:0] regAddr,
	input logic [phaseWidth-1:0] regData,
	input logic tblWr,
	input logic [tableAddrWidth-1:0] tblAddr,
	input logic [sampleWidth-1:0] tblData,
	output logic signed [sampleWidth+volWidth+$clog2(numChannels)-1:0] audio,
	output logic busReq,
	output logic [$clog2(numChannels)-1:0] busOwner
);

	localparam int chanBits = $clog2(numChannels);

	logic [numChannels-1:0] req;
	logic [numChannels-1:0] sel;
	logic [chanBits-1:0] owner;
	psgBusPkg::busCmd chanCmd [numChannels];
	logic [tableAddrWidth-1:0] chanAddr [numChannels];
	logic [numChannels-1:0][sampleWidth-1:0] samples;
	logic [numChannels-1:0][volWidth-1:0] volumes;
	logic [numChannels-1:0] enables;
	psgBusPkg::busCmd memCmd;
	logic [tableAddrWidth-1:0] memAddr;
	logic ack;
	logic dataVld;
	logic [sampleWidth-1:0] rdData;
	logic [chanBits-1:0] rdTag;

	// ========================================
	// voices
	// ========================================

	for (genvar i = 0; i < numChannels; i++) begin : gChan
		psgWaveChannel #(
			.chanId(i),
			.numChannels(numChannels),
			.sampleWidth(sampleWidth),
			.tableAddrWidth(tableAddrWidth),
			.phaseWidth(phaseWidth),
			.volWidth(volWidth)
		) uChan (
			.clk(clk), .rst(rst), .ce(ce),
			.regWr(regWr), .regAddr(regAddr), .regData(regData),
			.sel(sel), .ack(ack),
			.rdData(rdData), .rdTag(rdTag), .dataVld(dataVld),
			.req(req[i]), .cmd(chanCmd[i]), .addr(chanAddr[i]),
			.sample(samples[i]), .volume(volumes[i]), .enable(enables[i])
		);
	end

	// ========================================
	// shared wavetable port
	// ========================================

	// the memory ack paces regrants, so every voice gets its turn within one tick
	psgBusArb #(
		.numChannels(numChannels)
	) uArb (
		.clk(clk), .rst(rst), .ce(1'b1), .ack(ack),
		.req(req), .sel(sel), .owner(owner)
	);

	// owner steers the port
	assign memCmd = chanCmd[owner];
	assign memAddr = chanAddr[owner];

	psgWaveMem #(
		.sampleWidth(sampleWidth),
		.tableAddrWidth(tableAddrWidth),
		.tagWidth(chanBits)
	) uMem (
		.clk(clk), .rst(rst),
		.tblWr(tblWr), .tblAddr(tblAddr), .tblData(tblData),
		.cmd(memCmd), .addr(memAddr), .tag(owner),
		.ack(ack), .rdData(rdData), .rdTag(rdTag), .dataVld(dataVld)
	);

	psgMixer #(
		.numChannels(numChannels),
		.sampleWidth(sampleWidth),
		.volWidth(volWidth)
	) uMixer (
		.clk(clk), .rst(rst), .ce(ce),
		.samples(samples), .volumes(volumes), .enables(enables),
		.audio(audio)
	);

	// seen from outside as a single leaf of a larger arbitration tree
	assign busReq = |req;
	assign busOwner = owner;

endmodule

`default_nettype wire

/* tbClockGen.sv */
`timescale 1ns/1ps
`default_nettype none

// free-running clock and a synchronous reset for the testbench
module tbClockGen #(
	parameter int halfPeriod = 2,
	parameter int resetCycles = 2
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	// reset stays high across the first few rising edges
	initial begin
		rst = 1'b1;
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

/* psgWave_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module psgWave_tb;

	localparam int numChannels = 4;
	localparam int sampleWidth = 8;
	localparam int tableAddrWidth = 10;
	localparam int phaseWidth = 16;
	localparam int volWidth = 4;
	localparam int chanBits = $clog2(numChannels);
	localparam int audioWidth = sampleWidth + volWidth + chanBits;
	localparam int tickGap = 4 * numChannels + 4;
	localparam int wrNone = 0;
	localparam int wrReg = 1;
	localparam int wrTbl = 2;

	logic clk;
	logic rst;
	logic ce;
	logic regWr;
	logic [chanBits+1:0] regAddr;
	logic [phaseWidth-1:0] regData;
	logic tblWr;
	logic [tableAddrWidth-1:0] tblAddr;
	logic [sampleWidth-1:0] tblData;
	logic signed [audioWidth-1:0] audio;
	logic busReq;
	logic [chanBits-1:0] busOwner;

	int seed = 32'h382a44a3;
	int checks = 0;
	int errors = 0;
	int expAudio = 0;

	// reference model of the voices and the wavetable
	logic [sampleWidth-1:0] tblMirror [2**tableAddrWidth];
	logic [phaseWidth-1:0] mPhase [numChannels];
	logic [phaseWidth-1:0] mFreq [numChannels];
	logic [volWidth-1:0] mVol [numChannels];
	logic [tableAddrWidth-1:0] mBase [numChannels];
	logic mEn [numChannels];
	logic signed [sampleWidth-1:0] mSmp [numChannels];

	// stimulus table with one entry per row
	int rowKind[$];
	int rowChan[$];
	psgVoicePkg::regSel rowSel[$];
	int rowVal[$];
	int rowAddr[$];
	int rowTicks[$];
	int rowFirst[$];
	int rowOwner[$];

	tbClockGen uClk (.clk(clk), .rst(rst));

	psgWave u_dut (
		.clk(clk), .rst(rst), .ce(ce),
		.regWr(regWr), .regAddr(regAddr), .regData(regData),
		.tblWr(tblWr), .tblAddr(tblAddr), .tblData(tblData),
		.audio(audio), .busReq(busReq), .busOwner(busOwner)
	);

	task automatic addRow(input int kind, input int ch, input psgVoicePkg::regSel rs,
			input int val, input int ta, input int ticks, input int first, input int owner);
		rowKind.push_back(kind);
		rowChan.push_back(ch);
		rowSel.push_back(rs);
		rowVal.push_back(val);
		rowAddr.push_back(ta);
		rowTicks.push_back(ticks);
		rowFirst.push_back(first);
		rowOwner.push_back(owner);
	endtask

	// ========================================
	// compare tasks
	// ========================================

	task automatic checkAudio(input logic signed [audioWidth-1:0] got,
			input logic signed [audioWidth-1:0] want);
		checks++;
		if (got !== want) begin
			$display("[ERROR] %0t audio: got %0d, expected %0d", $time, got, want);
			errors++;
		end
	endtask

	task automatic checkOwner(input logic [chanBits-1:0] got, input logic [chanBits-1:0] want);
		checks++;
		if (got !== want) begin
			$display("[ERROR] %0t busOwner: got %0d, expected %0d", $time, got, want);
			errors++;
		end
	endtask

	task automatic checkReq(input logic got, input logic want);
		checks++;
		if (got !== want) begin
			$display("[ERROR] %0t busReq: got %b, expected %b", $time, got, want);
			errors++;
		end
	endtask

	// ========================================
	// drivers and model
	// ========================================

	task automatic writeTable(input int ta, input logic [sampleWidth-1:0] val);
		@(posedge clk);
		tblWr <= 1'b1;
		tblAddr <= tableAddrWidth'(ta);
		tblData <= val;
		tblMirror[ta] = val;
		@(posedge clk);
		tblWr <= 1'b0;
	endtask

	task automatic writeReg(input int ch, input psgVoicePkg::regSel rs, input int val);
		@(posedge clk);
		regWr <= 1'b1;
		regAddr <= {chanBits'(ch), rs};
		regData <= phaseWidth'(val);
		@(posedge clk);
		regWr <= 1'b0;
		case (rs)
			psgVoicePkg::regFreq: mFreq[ch] = phaseWidth'(val);
			psgVoicePkg::regVol: mVol[ch] = volWidth'(val);
			psgVoicePkg::regBase: mBase[ch] = tableAddrWidth'(val);
			psgVoicePkg::regCtrl: begin
				mEn[ch] = val[0];
				// switching a voice off drops its held sample
				if (!val[0]) begin
					mSmp[ch] = '0;
				end
			end
		endcase
	endtask

	// mix the held samples, then step the phases and fetch new table entries
	function automatic void modelTick();
		logic [phaseWidth-1:0] np;
		logic [tableAddrWidth-1:0] a;
		expAudio = 0;
		for (int i = 0; i < numChannels; i++) begin
			if (mEn[i]) begin
				expAudio += int'(mSmp[i]) * int'(mVol[i]);
			end
		end
		for (int i = 0; i < numChannels; i++) begin
			if (mEn[i]) begin
				np = mPhase[i] + mFreq[i];
				if (np[phaseWidth-1 -: tableAddrWidth]
						!= mPhase[i][phaseWidth-1 -: tableAddrWidth]) begin
					a = mBase[i] + np[phaseWidth-1 -: tableAddrWidth];
					mSmp[i] = tblMirror[a];
				end
				mPhase[i] = np;
			end
		end
	endfunction

	task automatic doTick(input bit chkFirst, input int expFirst);
		int seen;
		logic [chanBits-1:0] first;
		seen = 0;
		first = '0;
		@(posedge clk);
		ce <= 1'b1;
		@(posedge clk);
		ce <= 1'b0;
		modelTick();
		// the second cycle with busReq high shows the first grant
		for (int n = 0; n < tickGap; n++) begin
			@(negedge clk);
			if (busReq) begin
				seen++;
				if (seen == 2) begin
					first = busOwner;
				end
			end
		end
		if (busReq) begin
			$display("timeout: fetches still pending %0d cycles after the tick", tickGap);
			errors++;
		end
		checkAudio(audio, audioWidth'(expAudio));
		if (chkFirst) begin
			if (seen < 2) begin
				$display("no bus grant was seen after the tick at %0t", $time);
				errors++;
			end else begin
				checkOwner(first, chanBits'(expFirst));
			end
		end
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial begin
		int n;
		int rowErrs;
		ce <= 1'b0;
		regWr <= 1'b0;
		regAddr <= '0;
		regData <= '0;
		tblWr <= 1'b0;
		tblAddr <= '0;
		tblData <= '0;
		for (int i = 0; i < numChannels; i++) begin
			mPhase[i] = '0;
			mFreq[i] = '0;
			mVol[i] = '0;
			mBase[i] = '0;
			mEn[i] = 1'b0;
			mSmp[i] = '0;
		end

		// kind, chan, reg, value, table addr, ticks, first owner, final owner
		addRow(wrNone, 0, psgVoicePkg::regFreq, 0, 0, 0, -1, 0);
		addRow(wrNone, 0, psgVoicePkg::regFreq, 0, 0, 1, -1, 0);
		addRow(wrReg, 0, psgVoicePkg::regFreq, 64, 0, 0, -1, -1);
		addRow(wrReg, 0, psgVoicePkg::regVol, 5, 0, 0, -1, -1);
		addRow(wrReg, 0, psgVoicePkg::regBase, 100, 0, 0, -1, -1);
		addRow(wrReg, 0, psgVoicePkg::regCtrl, 1, 0, 3, 0, 0);
		addRow(wrReg, 1, psgVoicePkg::regFreq, 128, 0, 0, -1, -1);
		addRow(wrReg, 1, psgVoicePkg::regVol, 3, 0, 0, -1, -1);
		addRow(wrReg, 1, psgVoicePkg::regBase, 300, 0, 0, -1, -1);
		addRow(wrReg, 3, psgVoicePkg::regFreq, 64, 0, 0, -1, -1);
		addRow(wrReg, 3, psgVoicePkg::regVol, 7, 0, 0, -1, -1);
		addRow(wrReg, 3, psgVoicePkg::regBase, 700, 0, 0, -1, -1);
		addRow(wrReg, 0, psgVoicePkg::regCtrl, 0, 0, 0, -1, -1);
		addRow(wrReg, 1, psgVoicePkg::regCtrl, 1, 0, 0, -1, -1);
		addRow(wrReg, 3, psgVoicePkg::regCtrl, 1, 0, 1, 1, 3);
		// frozen phases leave the bus without requests
		addRow(wrReg, 1, psgVoicePkg::regFreq, 0, 0, 0, -1, -1);
		addRow(wrReg, 3, psgVoicePkg::regFreq, 0, 0, 1, -1, 3);
		addRow(wrReg, 0, psgVoicePkg::regCtrl, 1, 0, 2, 0, 0);
		addRow(wrTbl, 0, psgVoicePkg::regFreq, 8'h81, 106, 2, 0, 0);
		addRow(wrReg, 1, psgVoicePkg::regFreq, 200, 0, 0, -1, -1);
		addRow(wrReg, 3, psgVoicePkg::regFreq, 64, 0, 0, -1, -1);
		addRow(wrReg, 2, psgVoicePkg::regFreq, 1000, 0, 0, -1, -1);
		addRow(wrReg, 2, psgVoicePkg::regVol, 15, 0, 0, -1, -1);
		addRow(wrReg, 2, psgVoicePkg::regBase, 1000, 0, 0, -1, -1);
		// the owner left from the last tick fetches first, so the last grant alternates 3 and 2
		addRow(wrReg, 2, psgVoicePkg::regCtrl, 1, 0, 4, 0, 2);

		n = 0;
		while (rst && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (rst) begin
			$display("timeout: reset was never released");
			$display("Something failed");
			$finish;
		end

		for (int a = 0; a < 2**tableAddrWidth; a++) begin
			writeTable(a, sampleWidth'($random(seed)));
		end

		for (int r = 0; r < rowKind.size(); r++) begin
			rowErrs = errors;
			if (rowKind[r] == wrReg) begin
				writeReg(rowChan[r], rowSel[r], rowVal[r]);
			end else if (rowKind[r] == wrTbl) begin
				writeTable(rowAddr[r], sampleWidth'(rowVal[r]));
			end
			for (int t = 0; t < rowTicks[r]; t++) begin
				doTick(t == 0 && rowFirst[r] >= 0, rowFirst[r]);
			end
			@(negedge clk);
			checkReq(busReq, 1'b0);
			checkAudio(audio, audioWidth'(expAudio));
			if (rowOwner[r] >= 0) begin
				checkOwner(busOwner, chanBits'(rowOwner[r]));
			end
			if (errors == rowErrs) begin
				$display("row %0d: pass", r);
			end else begin
				$display("row %0d: %0d errors", r, errors - rowErrs);
			end
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* psgWave.f */
psgBusPkg.sv
psgVoicePkg.sv
psgBusArb.sv
psgWaveMem.sv
psgWaveChannel.sv
psgMixer.sv
psgWave.sv
tbClockGen.sv
psgWave_tb.sv

/* Makefile */
# Verilator build and run for the wavetable generator

VERILATOR ?= verilator
TOP ?= psgWave_tb
RTL_TOP ?= psgWave
FLIST ?= psgWave.f
BUILD_DIR ?= obj_dir
SIM_BIN ?= sim
LOG ?= sim.log
FAIL_MSG ?= Something failed
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR) -o $(SIM_BIN)

run: build
	./$(BUILD_DIR)/$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
